//--- list.f
verilog/ucode_pkg.sv
verilog/ucode_rom.sv
verilog/ucode_sequencer.sv
verilog/control_unit.sv
sim/control_unit_props.sv
sim/control_unit_tb.sv

//--- sim/control_unit_tb.sv
`timescale 1ns/1ps

module control_unit_tb;
  import ucode_pkg::*;

  localparam int MAX_CYCLES = 400;  // Sequences take about 200 cycles.

  typedef struct packed {
    logic [OPCODE_W-1:0] op;
    logic                zero;  // mlu_zero level during a branch.
    logic                irq;   // irq level until the next opword load.
  } prog_t;

  // Expected fields of one control word.
  typedef struct packed {
    in_plane_e              in_p;
    out_plane_e             out_p;
    reg_sel_e               reg_sel;
    misc_e                  misc;
    mlu_op_e                mlu;
    logic                   carry;
    shifter_e               shift;
    cond_sel_e              cond;
    logic [CTRL_DATA_W-1:0] data;
  } exp_t;

  logic                clk;
  logic                reset;
  logic [OPWORD_W-1:0] opword;
  logic                mlu_zero;
  logic                mlu_carry;
  logic                mlu_negative;
  logic                irq;
  ctrl_word_t          ctrl;

  prog_t   prog[$];
  opcode_e m_op;  // Reference model state.
  int      m_step;
  logic    m_cond;
  logic    m_ie;
  logic    irq_level;
  logic    zero_level;
  int      idx;
  int      seed = 2;
  int      cycles = 0;
  int      checks = 0;
  int      errors = 0;

  control_unit dut0 (
    .clk          (clk),
    .reset        (reset),
    .opword       (opword),
    .mlu_zero     (mlu_zero),
    .mlu_carry    (mlu_carry),
    .mlu_negative (mlu_negative),
    .irq          (irq),
    .ctrl         (ctrl)
  );

  always #10 clk = ~clk;

  function automatic exp_t make_expect(input in_plane_e i, input out_plane_e o,
                                       input reg_sel_e r);
    exp_t e;
    e.in_p = i;
    e.out_p = o;
    e.reg_sel = r;
    e.misc = MISC_NONE;
    e.mlu = MLU_ADD;
    e.carry = 1'b0;
    e.shift = SHIFTER_LEFT;
    e.cond = COND_MLU_ZERO;
    e.data = '0;
    return e;
  endfunction

  function automatic exp_t expect_word(input opcode_e op, input int step, input logic cond);
    exp_t e;
    logic jump;
    logic three_reg;
    logic shift_op;
    e = make_expect(IN_NONE, OUT_NONE, OPWORD0);
    jump = 1'b0;
    three_reg = op inside {OP_ADD3, OP_OR3, OP_XOR3, OP_SLL3};
    shift_op = op inside {OP_SLL3, OP_SLL, OP_SRL};
    case (op)
      OP_RESET: begin
        case (step)
          0: begin
            e = make_expect(IN_TMP0, OUT_CTRL_DATA, OPWORD0);
            e.data = 8'd1;
          end
          1: e = make_expect(IN_REG, OUT_TMP0, CONTROL);  // PC takes its start value.
          default: jump = 1'b1;
        endcase
      end
      OP_FETCH: begin
        case (step)
          0: begin
            e = make_expect(IN_TMP0, OUT_REG, CONTROL);
            e.cond = COND_INTERRUPT;
          end
          1: begin
            if (cond) begin
              jump = 1'b1;  // Pending interrupt.
            end else begin
              e = make_expect(IN_OPWORD, OUT_MMU, OPWORD0);
            end
          end
          2: begin
            e = make_expect(IN_TMP1, OUT_CTRL_DATA, OPWORD0);
            e.data = 8'd1;  // PC increment.
          end
          3: e = make_expect(IN_REG, OUT_MLU, CONTROL);
          default: begin
            e.in_p = IN_OPCODE;
            e.misc = MISC_RESET_MICROOP_COUNTER;
          end
        endcase
      end
      OP_INT: begin
        case (step)
          0: begin
            e = make_expect(IN_TMP0, OUT_CTRL_DATA, OPWORD0);
            e.misc = MISC_SET_INTERRUPTS;
          end
          1: e = make_expect(IN_REG, OUT_MMU, CONTROL);
          default: jump = 1'b1;
        endcase
      end
      OP_SETI, OP_CLRI: begin
        if (step == 0) begin
          e.misc = MISC_SET_INTERRUPTS;
          e.data = (op == OP_SETI) ? 8'd1 : 8'd0;  // Bit 0 is the new enable.
        end else begin
          jump = 1'b1;
        end
      end
      OP_ADD3, OP_OR3, OP_XOR3, OP_SLL3, OP_ADDU, OP_AND, OP_SLL, OP_SRL: begin
        case (step)
          0: e = make_expect(IN_TMP0, OUT_REG, OPWORD1);
          1: e = make_expect(IN_TMP1, three_reg ? OUT_REG : OUT_OPWORD_IMMEDIATE, OPWORD2);
          2: begin
            e = make_expect(IN_REG, shift_op ? OUT_SHIFTER : OUT_MLU, OPWORD0);
            if (op == OP_SRL) e.shift = SHIFTER_RIGHT;
            else if (op == OP_OR3) e.mlu = MLU_OR;
            else if (op == OP_XOR3) e.mlu = MLU_XOR;
            else if (op == OP_AND) e.mlu = MLU_AND;
          end
          default: jump = 1'b1;
        endcase
      end
      OP_BEQ, OP_BNE: begin
        case (step)
          0: e = make_expect(IN_TMP0, OUT_REG, OPWORD0);
          1: e = make_expect(IN_TMP1, OUT_REG, OPWORD1);
          2: begin
            e.mlu = MLU_SUB;
            e.carry = 1'b1;
          end
          3: begin
            if (cond == (op == OP_BEQ)) begin
              e = make_expect(IN_TMP0, OUT_OPWORD_IMMEDIATE, OPWORD0);  // Branch taken.
            end else begin
              jump = 1'b1;
            end
          end
          4: e = make_expect(IN_TMP1, OUT_NONE, OPWORD0);
          5: begin
            e = make_expect(IN_TMP1, OUT_SHIFTER, OPWORD0);
            e.shift = SHIFTER_SIGNEXT16;
          end
          6: e = make_expect(IN_TMP0, OUT_REG, CONTROL);
          7: e = make_expect(IN_REG, OUT_MLU, CONTROL);
          default: jump = 1'b1;
        endcase
      end
      default: jump = 1'b1;
    endcase
    if (jump) begin
      e = make_expect(IN_OPCODE, OUT_CTRL_DATA, OPWORD0);
      e.misc = MISC_RESET_MICROOP_COUNTER;
      e.data = (op == OP_FETCH) ? CTRL_DATA_W'(OP_INT) : CTRL_DATA_W'(OP_FETCH);
    end
    return e;
  endfunction

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %s got 0x%0h expected 0x%0h (opcode 0x%0h step %0d)",
               name, got, exp, m_op, m_step);
    end
  endtask

  task automatic check_word(input exp_t e);
    check_field("ctrl.in_plane", ctrl.in_plane, e.in_p);
    check_field("ctrl.out_plane", ctrl.out_plane, e.out_p);
    check_field("ctrl.misc", ctrl.misc, e.misc);
    check_field("ctrl.mlu_op", ctrl.mlu_op, e.mlu);
    check_field("ctrl.mlu_carry", ctrl.mlu_carry, e.carry);
    check_field("ctrl.shifter", ctrl.shifter, e.shift);
    check_field("ctrl.shifter_arith", ctrl.shifter_arith, 1'b0);
    check_field("ctrl.cond_sel", ctrl.cond_sel, e.cond);
    // Register select only matters while the register file is on the bus.
    if (e.in_p == IN_REG || e.out_p == OUT_REG) begin
      check_field("ctrl.reg_sel", ctrl.reg_sel, e.reg_sel);
      if (e.reg_sel == CONTROL) check_field("ctrl.ctrl_data", ctrl.ctrl_data, REG_PC);
    end
    // Constant on the bus or new interrupt enable.
    if (e.out_p == OUT_CTRL_DATA || e.misc == MISC_SET_INTERRUPTS) begin
      check_field("ctrl.ctrl_data", ctrl.ctrl_data, e.data);
    end
    if (e.in_p == IN_OPCODE) begin
      check_field("ctrl.opcode_sel", ctrl.opcode_sel,
                  (m_op == OP_FETCH && m_step == 4) ? FROM_OPWORD : FROM_BUS);
    end
  endtask

  // Next state by the sequencer rules, using the inputs just driven.
  task automatic step_model(input exp_t e);
    if (m_op == OP_FETCH && m_step == 0) m_cond = irq & m_ie;
    else m_cond = mlu_zero;
    if (e.misc == MISC_SET_INTERRUPTS) m_ie = (m_op == OP_SETI);
    if (e.in_p == IN_OPCODE) begin
      if (m_op == OP_FETCH && m_step == 4) begin
        m_op = opcode_e'(opword[OPWORD_W-1 -: OPCODE_W]);
        irq_level = prog[idx].irq;
        zero_level = prog[idx].zero;
        idx++;
      end else if (m_op == OP_FETCH) begin
        m_op = OP_INT;
      end else begin
        m_op = OP_FETCH;
      end
    end
    m_step = (e.misc == MISC_RESET_MICROOP_COUNTER) ? 0 : m_step + 1;
  endtask

  task automatic queue_instr(input logic [OPCODE_W-1:0] op, input logic zero,
                             input logic irq_in);
    prog.push_back(prog_t'{op, zero, irq_in});
  endtask

  task automatic finish_run(input logic timed_out);
    int prop_fails;
    prop_fails = dut0.seq0.props0.fail_count;
    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, prop_fails);
    if (!timed_out && errors == 0 && prop_fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: the instruction sequence did not finish in %0d cycles", MAX_CYCLES);
      finish_run(1'b1);
    end
  end

  initial begin
    exp_t        e;
    logic [31:0] rnd;
    clk = 1'b0;
    reset = 1'b1;
    opword = '0;
    mlu_zero = 1'b0;
    mlu_carry = 1'b0;
    mlu_negative = 1'b0;
    irq = 1'b0;
    m_op = OP_RESET;
    m_step = 0;
    m_cond = 1'b0;
    m_ie = 1'b0;
    irq_level = 1'b0;
    zero_level = 1'b0;
    idx = 0;
    queue_instr(OP_ADD3, 1'b0, 1'b0);
    queue_instr(OP_OR3, 1'b0, 1'b0);
    queue_instr(OP_XOR3, 1'b0, 1'b0);
    queue_instr(OP_SLL3, 1'b0, 1'b0);
    queue_instr(OP_ADDU, 1'b0, 1'b0);
    queue_instr(OP_AND, 1'b0, 1'b0);
    queue_instr(OP_SLL, 1'b0, 1'b0);
    queue_instr(OP_SRL, 1'b0, 1'b0);
    queue_instr(OP_BEQ, 1'b1, 1'b0);
    queue_instr(OP_BEQ, 1'b0, 1'b0);
    queue_instr(OP_BNE, 1'b1, 1'b0);
    queue_instr(OP_BNE, 1'b0, 1'b0);
    queue_instr(OP_SETI, 1'b0, 1'b0);
    queue_instr(OP_CLRI, 1'b0, 1'b1);  // Request stays masked.
    queue_instr(OP_SETI, 1'b0, 1'b1);  // Next fetch enters INT.
    queue_instr(6'd9, 1'b0, 1'b0);
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    while (!(m_op == OP_FETCH && m_step == 0 && idx == prog.size())) begin
      e = expect_word(m_op, m_step, m_cond);
      check_word(e);
      rnd = $random(seed);
      if (m_op == OP_FETCH && m_step == 0) begin
        opword = {prog[idx].op, rnd[31:6]};
      end
      mlu_carry = rnd[0];
      mlu_negative = rnd[1];
      mlu_zero = (m_op == OP_BEQ || m_op == OP_BNE) ? zero_level : rnd[2];
      irq = irq_level;
      step_model(e);
      @(negedge clk);
    end
    e = expect_word(m_op, m_step, m_cond);  // Fresh fetch after the last instruction.
    check_word(e);
    finish_run(1'b0);
  end

endmodule

//--- sim/control_unit_props.sv
`timescale 1ns/1ps

module control_unit_props (
  input logic                        clk,
  input logic                        reset,
  input ucode_pkg::ctrl_word_t       ctrl,
  input ucode_pkg::opcode_e          opcode,
  input logic [ucode_pkg::UOP_W-1:0] uop_count
);
  import ucode_pkg::*;

  int unsigned fail_count = 0;  // Failed assertion attempts.

  // A finished instruction restarts at step 0.
  count_restart: assert property (@(posedge clk) disable iff (reset)
      ctrl.misc == MISC_RESET_MICROOP_COUNTER |=> uop_count == '0)
    else begin
      $error("micro-op counter did not return to 0 after a counter reset word");
      fail_count++;
    end

  count_step: assert property (@(posedge clk) disable iff (reset)
      ctrl.misc != MISC_RESET_MICROOP_COUNTER |=>
      uop_count == UOP_W'($past(uop_count) + 1'b1))
    else begin
      $error("micro-op counter did not increment");
      fail_count++;
    end

  // Only an IN_OPCODE word may load a new opcode.
  opcode_hold: assert property (@(posedge clk) disable iff (reset)
      ctrl.in_plane != IN_OPCODE |=> $stable(opcode))
    else begin
      $error("opcode changed without an IN_OPCODE word");
      fail_count++;
    end

endmodule

bind ucode_sequencer control_unit_props props0 (
  .clk       (clk),
  .reset     (reset),
  .ctrl      (ctrl),
  .opcode    (opcode),
  .uop_count (uop_count)
);

//--- verilog/control_unit.sv
`timescale 1ns/1ps

module control_unit (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [ucode_pkg::OPWORD_W-1:0]   opword,  // From the datapath opword register.
  input  logic                             mlu_zero,
  input  logic                             mlu_carry,
  input  logic                             mlu_negative,
  input  logic                             irq,
  output ucode_pkg::ctrl_word_t            ctrl
);
  import ucode_pkg::*;

  opcode_e          opcode;
  logic [UOP_W-1:0] uop_count;
  logic             cond_var;

  ucode_sequencer seq0 (
    .clk          (clk),
    .reset        (reset),
    .ctrl         (ctrl),
    .opword       (opword),
    .mlu_zero     (mlu_zero),
    .mlu_carry    (mlu_carry),
    .mlu_negative (mlu_negative),
    .irq          (irq),
    .opcode       (opcode),
    .uop_count    (uop_count),
    .cond_var     (cond_var)
  );

  // Control word is a pure function of the sequencer state.
  ucode_rom rom0 (
    .opcode    (opcode),
    .uop_count (uop_count),
    .cond_var  (cond_var),
    .ctrl      (ctrl)
  );

endmodule

//--- verilog/ucode_sequencer.sv
`timescale 1ns/1ps

module ucode_sequencer (
  input  logic                             clk,
  input  logic                             reset,
  input  ucode_pkg::ctrl_word_t            ctrl,
  input  logic [ucode_pkg::OPWORD_W-1:0]   opword,
  input  logic                             mlu_zero,
  input  logic                             mlu_carry,
  input  logic                             mlu_negative,
  input  logic                             irq,
  output ucode_pkg::opcode_e               opcode,
  output logic [ucode_pkg::UOP_W-1:0]      uop_count,
  output logic                             cond_var
);
  import ucode_pkg::*;

  logic    int_enable;
  opcode_e next_opcode;
  logic    cond_next;

  // Opcode source for an IN_OPCODE word.
  always_comb begin
    if (ctrl.opcode_sel == FROM_BUS) begin
      next_opcode = opcode_e'(ctrl.ctrl_data[OPCODE_W-1:0]);
    end else begin
      next_opcode = opcode_e'(opword[OPWORD_W-1 -: OPCODE_W]);  // Top bits of the opword.
    end
  end

  always_comb begin
    case (ctrl.cond_sel)
      COND_MLU_ZERO:     cond_next = mlu_zero;
      COND_MLU_CARRY:    cond_next = mlu_carry;
      COND_MLU_NEGATIVE: cond_next = mlu_negative;
      COND_INTERRUPT:    cond_next = irq & int_enable;  // Masked interrupt request.
      default:           cond_next = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      uop_count <= '0;
    end else if (ctrl.misc == MISC_RESET_MICROOP_COUNTER) begin
      uop_count <= '0;  // Instruction finished.
    end else begin
      uop_count <= uop_count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      opcode <= OP_RESET;
    end else if (ctrl.in_plane == IN_OPCODE) begin
      opcode <= next_opcode;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      int_enable <= 1'b0;
    end else if (ctrl.misc == MISC_SET_INTERRUPTS) begin
      int_enable <= ctrl.ctrl_data[0];
    end
  end

  // Sampled every cycle, consumed by the next micro-op.
  always_ff @(posedge clk) begin
    if (reset) begin
      cond_var <= 1'b0;
    end else begin
      cond_var <= cond_next;
    end
  end

endmodule

//--- verilog/ucode_rom.sv
`timescale 1ns/1ps

module ucode_rom (
  input  ucode_pkg::opcode_e             opcode,
  input  logic [ucode_pkg::UOP_W-1:0]    uop_count,
  input  logic                           cond_var,
  output ucode_pkg::ctrl_word_t          ctrl
);
  import ucode_pkg::*;

  logic     three_reg;  // Second ALU operand comes from a register.
  logic     use_shifter;  // Result taken from the shifter, not the MLU.
  mlu_op_e  alu_mlu_op;
  shifter_e alu_shift;
  logic     branch_taken;

  // Word that loads a new opcode from ctrl_data and restarts the counter.
  function automatic ctrl_word_t jump_to(input opcode_e target);
    ctrl_word_t w;
    w = '0;
    w.ctrl_data = CTRL_DATA_W'(target);
    w.out_plane = OUT_CTRL_DATA;
    w.in_plane = IN_OPCODE;
    w.misc = MISC_RESET_MICROOP_COUNTER;
    w.opcode_sel = FROM_BUS;
    return w;
  endfunction

  // ALU group decode.
  always_comb begin
    three_reg = 1'b0;
    use_shifter = 1'b0;
    alu_mlu_op = MLU_ADD;
    alu_shift = SHIFTER_LEFT;
    case (opcode)
      OP_ADD3: begin
        three_reg = 1'b1;
      end
      OP_OR3: begin
        three_reg = 1'b1;
        alu_mlu_op = MLU_OR;
      end
      OP_XOR3: begin
        three_reg = 1'b1;
        alu_mlu_op = MLU_XOR;
      end
      OP_SLL3: begin
        three_reg = 1'b1;
        use_shifter = 1'b1;
      end
      OP_AND: begin
        alu_mlu_op = MLU_AND;
      end
      OP_SLL: begin
        use_shifter = 1'b1;
      end
      OP_SRL: begin
        use_shifter = 1'b1;
        alu_shift = SHIFTER_RIGHT;
      end
      default: begin
        three_reg = 1'b0;  // ADDU and everything else.
      end
    endcase
  end

  // BEQ branches on a zero result, BNE on a nonzero one.
  assign branch_taken = (opcode == OP_BEQ) ? cond_var : !cond_var;

  always_comb begin
    ctrl = '0;
    case (opcode)
      OP_RESET: begin
        case (uop_count)
          0: begin
            ctrl.ctrl_data = 8'd1;
            ctrl.out_plane = OUT_CTRL_DATA;
            ctrl.in_plane = IN_TMP0;
          end
          1: begin  // PC starts at 1.
            ctrl.ctrl_data = REG_PC;
            ctrl.reg_sel = CONTROL;
            ctrl.out_plane = OUT_TMP0;
            ctrl.in_plane = IN_REG;
          end
          2: ctrl = jump_to(OP_FETCH);
          default: ctrl = '0;
        endcase
      end
      OP_FETCH: begin
        case (uop_count)
          0: begin  // PC to TMP0 as the fetch address, sample the interrupt.
            ctrl.ctrl_data = REG_PC;
            ctrl.reg_sel = CONTROL;
            ctrl.out_plane = OUT_REG;
            ctrl.in_plane = IN_TMP0;
            ctrl.cond_sel = COND_INTERRUPT;
          end
          1: begin
            if (cond_var) begin
              ctrl = jump_to(OP_INT);  // Pending interrupt wins over the fetch.
            end else begin
              ctrl.out_plane = OUT_MMU;
              ctrl.in_plane = IN_OPWORD;
            end
          end
          2: begin
            ctrl.ctrl_data = 8'd1;  // Increment for the PC.
            ctrl.reg_sel = CONTROL;
            ctrl.out_plane = OUT_CTRL_DATA;
            ctrl.in_plane = IN_TMP1;
          end
          3: begin
            ctrl.ctrl_data = REG_PC;
            ctrl.reg_sel = CONTROL;
            ctrl.out_plane = OUT_MLU;
            ctrl.in_plane = IN_REG;
            ctrl.mlu_op = MLU_ADD;
          end
          4: begin  // Opcode from the opword just read.
            ctrl.in_plane = IN_OPCODE;
            ctrl.misc = MISC_RESET_MICROOP_COUNTER;
            ctrl.opcode_sel = FROM_OPWORD;
          end
          default: ctrl = '0;
        endcase
      end
      OP_INT: begin
        case (uop_count)
          0: begin  // Vector address 0, interrupts off.
            ctrl.ctrl_data = 8'd0;
            ctrl.out_plane = OUT_CTRL_DATA;
            ctrl.in_plane = IN_TMP0;
            ctrl.misc = MISC_SET_INTERRUPTS;
          end
          1: begin
            ctrl.ctrl_data = REG_PC;
            ctrl.reg_sel = CONTROL;
            ctrl.out_plane = OUT_MMU;
            ctrl.in_plane = IN_REG;
          end
          2: ctrl = jump_to(OP_FETCH);
          default: ctrl = '0;
        endcase
      end
      OP_SETI, OP_CLRI: begin
        case (uop_count)
          0: begin
            ctrl.ctrl_data = (opcode == OP_SETI) ? 8'd1 : 8'd0;
            ctrl.misc = MISC_SET_INTERRUPTS;
          end
          1: ctrl = jump_to(OP_FETCH);
          default: ctrl = '0;
        endcase
      end
      OP_ADD3, OP_OR3, OP_XOR3, OP_SLL3, OP_ADDU, OP_AND, OP_SLL, OP_SRL: begin
        case (uop_count)
          0: begin  // First source into TMP0.
            ctrl.reg_sel = OPWORD1;
            ctrl.out_plane = OUT_REG;
            ctrl.in_plane = IN_TMP0;
          end
          1: begin  // Second source, a register or the immediate.
            if (three_reg) begin
              ctrl.reg_sel = OPWORD2;
              ctrl.out_plane = OUT_REG;
            end else begin
              ctrl.out_plane = OUT_OPWORD_IMMEDIATE;
            end
            ctrl.in_plane = IN_TMP1;
          end
          2: begin
            ctrl.reg_sel = OPWORD0;
            ctrl.in_plane = IN_REG;
            if (use_shifter) begin
              ctrl.out_plane = OUT_SHIFTER;
              ctrl.shifter = alu_shift;
            end else begin
              ctrl.out_plane = OUT_MLU;
              ctrl.mlu_op = alu_mlu_op;
            end
          end
          3: ctrl = jump_to(OP_FETCH);
          default: ctrl = '0;
        endcase
      end
      OP_BEQ, OP_BNE: begin
        case (uop_count)
          0: begin
            ctrl.reg_sel = OPWORD0;
            ctrl.out_plane = OUT_REG;
            ctrl.in_plane = IN_TMP0;
          end
          1: begin
            ctrl.reg_sel = OPWORD1;
            ctrl.out_plane = OUT_REG;
            ctrl.in_plane = IN_TMP1;
          end
          2: begin  // Compare, zero flag lands in cond_var.
            ctrl.mlu_op = MLU_SUB;
            ctrl.mlu_carry = 1'b1;
            ctrl.cond_sel = COND_MLU_ZERO;
          end
          3: begin
            if (branch_taken) begin
              ctrl.out_plane = OUT_OPWORD_IMMEDIATE;
              ctrl.in_plane = IN_TMP0;
            end else begin
              ctrl = jump_to(OP_FETCH);
            end
          end
          4: begin  // Shift amount of zero.
            ctrl.out_plane = OUT_NONE;
            ctrl.in_plane = IN_TMP1;
          end
          5: begin
            ctrl.shifter = SHIFTER_SIGNEXT16;
            ctrl.out_plane = OUT_SHIFTER;
            ctrl.in_plane = IN_TMP1;
          end
          6: begin
            ctrl.ctrl_data = REG_PC;
            ctrl.reg_sel = CONTROL;
            ctrl.out_plane = OUT_REG;
            ctrl.in_plane = IN_TMP0;
          end
          7: begin  // PC plus offset.
            ctrl.ctrl_data = REG_PC;
            ctrl.reg_sel = CONTROL;
            ctrl.out_plane = OUT_MLU;
            ctrl.in_plane = IN_REG;
            ctrl.mlu_op = MLU_ADD;
          end
          8: ctrl = jump_to(OP_FETCH);
          default: ctrl = '0;
        endcase
      end
      default: ctrl = jump_to(OP_FETCH);  // Unsupported opcode.
    endcase
  end

endmodule

//--- verilog/ucode_pkg.sv
package ucode_pkg;

  localparam int OPWORD_W = 32;  // Instruction word.
  localparam int OPCODE_W = 6;  // Opcode sits in the top bits of the opword.
  localparam int UOP_W = 5;  // Micro-op counter.
  localparam int CTRL_DATA_W = 8;  // Constant field of the control word.

  localparam logic [CTRL_DATA_W-1:0] REG_PC = 8'd31;  // r31 holds the program counter.

  // Instruction opcodes. Values outside this set run as a single go-fetch step.
  typedef enum logic [OPCODE_W-1:0] {
    OP_RESET = 6'd0,
    OP_FETCH = 6'd1,
    OP_ADDU  = 6'd3,   // rD = rS + zeroext(I).
    OP_ADD3  = 6'd4,   // rD = rA + rB.
    OP_OR3   = 6'd6,   // rD = rA | rB.
    OP_BEQ   = 6'd8,   // if rA == rB then r31 += signext(I).
    OP_SLL   = 6'd10,  // rD = rS << I.
    OP_BNE   = 6'd11,  // if rA != rB then r31 += signext(I).
    OP_AND   = 6'd12,  // rD = rS & zeroext(I).
    OP_XOR3  = 6'd13,  // rD = rA ^ rB.
    OP_SRL   = 6'd14,  // rD = rS >> I.
    OP_SLL3  = 6'd15,  // rD = rA << rB.
    OP_INT   = 6'd16,
    OP_SETI  = 6'd17,
    OP_CLRI  = 6'd18
  } opcode_e;

  typedef enum logic [1:0] {
    OPWORD0 = 2'd0,  // Destination field of the opword.
    OPWORD1 = 2'd1,
    OPWORD2 = 2'd2,
    CONTROL = 2'd3   // Register number comes from ctrl_data.
  } reg_sel_e;

  typedef enum logic [3:0] {
    OUT_NONE             = 4'd0,
    OUT_REG              = 4'd1,
    OUT_TMP0             = 4'd2,
    OUT_TMP1             = 4'd3,
    OUT_MMU              = 4'd4,
    OUT_MLU              = 4'd5,
    OUT_SHIFTER          = 4'd6,
    OUT_TIMER            = 4'd7,
    OUT_CTRL_DATA        = 4'd8,
    OUT_OPWORD_IMMEDIATE = 4'd9
  } out_plane_e;

  typedef enum logic [2:0] {
    IN_NONE   = 3'd0,
    IN_REG    = 3'd1,
    IN_TMP0   = 3'd2,
    IN_TMP1   = 3'd3,
    IN_MMU    = 3'd4,
    IN_OPWORD = 3'd5,
    IN_OPCODE = 3'd6
  } in_plane_e;

  typedef enum logic [1:0] {
    MISC_NONE                  = 2'd0,
    MISC_RESET_MICROOP_COUNTER = 2'd1,
    MISC_SET_INTERRUPTS        = 2'd2  // Enable takes ctrl_data bit 0.
  } misc_e;

  typedef enum logic [2:0] {
    MLU_ADD = 3'd0,
    MLU_SUB = 3'd1,
    MLU_AND = 3'd2,
    MLU_OR  = 3'd3,
    MLU_XOR = 3'd4
  } mlu_op_e;

  typedef enum logic [1:0] {
    SHIFTER_LEFT      = 2'd0,
    SHIFTER_RIGHT     = 2'd1,
    SHIFTER_SIGNEXT16 = 2'd2
  } shifter_e;

  typedef enum logic {
    FROM_OPWORD = 1'b0,
    FROM_BUS    = 1'b1
  } opcode_sel_e;

  // Flag sampled into the condition bit for the next micro-op.
  typedef enum logic [1:0] {
    COND_MLU_ZERO     = 2'd0,
    COND_MLU_CARRY    = 2'd1,
    COND_MLU_NEGATIVE = 2'd2,
    COND_INTERRUPT    = 2'd3
  } cond_sel_e;

  typedef struct packed {
    logic [2:0]             pad;
    cond_sel_e              cond_sel;
    opcode_sel_e            opcode_sel;
    logic                   shifter_arith;
    shifter_e               shifter;
    logic                   mlu_carry;
    mlu_op_e                mlu_op;
    misc_e                  misc;
    in_plane_e              in_plane;
    out_plane_e             out_plane;
    reg_sel_e               reg_sel;
    logic [CTRL_DATA_W-1:0] ctrl_data;  // Low byte of the word.
  } ctrl_word_t;

endpackage
